//--- logic/mipsPkg.sv
`default_nettype none

package mipsPkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regAddr_t;
    typedef logic [4:0]  shamt_t;
    typedef logic [4:0]  aluCtrl_t;
    typedef logic [4:0]  branchCond_t;

    localparam int regCount = 32;

    // primary opcodes
    localparam logic [5:0] opSpecial = 6'h00;
    localparam logic [5:0] opJ       = 6'h02;
    localparam logic [5:0] opBeq     = 6'h04;
    localparam logic [5:0] opBne     = 6'h05;
    localparam logic [5:0] opAddiu   = 6'h09;
    localparam logic [5:0] opOri     = 6'h0d;
    localparam logic [5:0] opLui     = 6'h0f;

    // funct field, special opcode only
    localparam logic [5:0] fnSll  = 6'h00;
    localparam logic [5:0] fnSrl  = 6'h02;
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd  = 6'h24;
    localparam logic [5:0] fnOr   = 6'h25;
    localparam logic [5:0] fnXor  = 6'h26;
    localparam logic [5:0] fnSlt  = 6'h2a;

    localparam aluCtrl_t aluAdd = 5'd0;
    localparam aluCtrl_t aluSub = 5'd1;
    localparam aluCtrl_t aluAnd = 5'd2;
    localparam aluCtrl_t aluOr  = 5'd3;
    localparam aluCtrl_t aluXor = 5'd4;
    localparam aluCtrl_t aluSlt = 5'd5; // signed
    localparam aluCtrl_t aluSll = 5'd6;
    localparam aluCtrl_t aluSrl = 5'd7;
    localparam aluCtrl_t aluLui = 5'd8; // passes the upper-half immediate

    localparam branchCond_t brNone = 5'd0;
    localparam branchCond_t brEq   = 5'd1;
    localparam branchCond_t brNe   = 5'd2;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
        logic  predTake;
        logic  inDelaySlot;
    } fetchPkt_t;

    typedef struct packed {
        logic        valid;
        word_t       pc;
        word_t       pcPlus4;
        word_t       instr;
        word_t       pcBranch;   // branch or jump target
        word_t       rd1;
        word_t       rd2;
        regAddr_t    rs;
        regAddr_t    rt;
        regAddr_t    dest;
        word_t       imm;        // already extended
        shamt_t      sa;
        aluCtrl_t    aluControl;
        logic        useImm;
        logic        regWrite;
        logic        branch;
        logic        jump;
        branchCond_t branchCond;
        logic        predTake;
        logic        inDelaySlot;
    } decodePkt_t;

    typedef struct packed {
        logic     en;
        regAddr_t addr;
        word_t    data;
    } wbReq_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        regAddr_t dest;
        logic     regWrite;
        word_t    value;
    } exResult_t;

    typedef struct packed {
        logic  valid;
        logic  taken;
        logic  mispredict;
        word_t target;
    } resolve_t;

endpackage

`default_nettype wire

//--- logic/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
    input  logic                clk,
    input  logic                rstN,
    input  mipsPkg::fetchPkt_t  fetch,
    input  mipsPkg::wbReq_t     wb,
    output mipsPkg::decodePkt_t decoded
);

    mipsPkg::word_t regFile [mipsPkg::regCount];

    logic [5:0]           opcode;
    logic [5:0]           funct;
    logic [15:0]          imm16;
    mipsPkg::regAddr_t    rs;
    mipsPkg::regAddr_t    rt;
    mipsPkg::regAddr_t    rd;
    mipsPkg::word_t       signImm;
    mipsPkg::word_t       zeroImm;
    mipsPkg::word_t       upperImm;
    mipsPkg::word_t       pcPlus4;
    mipsPkg::word_t       branchTarget;
    mipsPkg::word_t       jumpTarget;
    mipsPkg::word_t       rd1;
    mipsPkg::word_t       rd2;

    mipsPkg::aluCtrl_t    aluControl;
    mipsPkg::branchCond_t branchCond;
    mipsPkg::word_t       imm;
    logic                 useImm;
    logic                 regWrite;
    logic                 branch;
    logic                 jump;
    logic                 destIsRd;

    assign opcode = fetch.instr[31:26];
    assign rs     = fetch.instr[25:21];
    assign rt     = fetch.instr[20:16];
    assign rd     = fetch.instr[15:11];
    assign funct  = fetch.instr[5:0];
    assign imm16  = fetch.instr[15:0];

    assign signImm  = {{16{imm16[15]}}, imm16};
    assign zeroImm  = {16'h0000, imm16};
    assign upperImm = {imm16, 16'h0000};

    assign pcPlus4      = fetch.pc + 32'd4;
    assign branchTarget = pcPlus4 + {signImm[29:0], 2'b00};
    assign jumpTarget   = {pcPlus4[31:28], fetch.instr[25:0], 2'b00}; // same 256MB region

    always_comb begin
        aluControl = mipsPkg::aluAdd;
        branchCond = mipsPkg::brNone;
        imm        = signImm;
        useImm     = 1'b0;
        regWrite   = 1'b0;
        branch     = 1'b0;
        jump       = 1'b0;
        destIsRd   = 1'b0;
        case (opcode)
            mipsPkg::opSpecial: begin
                destIsRd = 1'b1;
                regWrite = 1'b1;
                case (funct)
                    mipsPkg::fnAddu: aluControl = mipsPkg::aluAdd;
                    mipsPkg::fnSubu: aluControl = mipsPkg::aluSub;
                    mipsPkg::fnAnd:  aluControl = mipsPkg::aluAnd;
                    mipsPkg::fnOr:   aluControl = mipsPkg::aluOr;
                    mipsPkg::fnXor:  aluControl = mipsPkg::aluXor;
                    mipsPkg::fnSlt:  aluControl = mipsPkg::aluSlt;
                    mipsPkg::fnSll:  aluControl = mipsPkg::aluSll;
                    mipsPkg::fnSrl:  aluControl = mipsPkg::aluSrl;
                    default:         regWrite   = 1'b0; // unsupported funct is a no-op
                endcase
            end
            mipsPkg::opAddiu: begin
                aluControl = mipsPkg::aluAdd;
                useImm     = 1'b1;
                regWrite   = 1'b1;
            end
            mipsPkg::opOri: begin
                aluControl = mipsPkg::aluOr;
                imm        = zeroImm;
                useImm     = 1'b1;
                regWrite   = 1'b1;
            end
            mipsPkg::opLui: begin
                aluControl = mipsPkg::aluLui;
                imm        = upperImm;
                useImm     = 1'b1;
                regWrite   = 1'b1;
            end
            mipsPkg::opBeq: begin
                branch     = 1'b1;
                branchCond = mipsPkg::brEq;
            end
            mipsPkg::opBne: begin
                branch     = 1'b1;
                branchCond = mipsPkg::brNe;
            end
            mipsPkg::opJ:  jump = 1'b1;
            default: ;  // unknown opcode, no-op
        endcase
    end

    // register file, $0 never written
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < mipsPkg::regCount; i++) begin
                regFile[i] <= '0;
            end
        end else if (wb.en && wb.addr != '0) begin
            regFile[wb.addr] <= wb.data;
        end
    end

    // write-through so a dependent instruction right behind sees the new value
    assign rd1 = (rs == '0) ? '0 : (wb.en && wb.addr == rs) ? wb.data : regFile[rs];
    assign rd2 = (rt == '0) ? '0 : (wb.en && wb.addr == rt) ? wb.data : regFile[rt];

    always_comb begin
        decoded.valid       = fetch.valid;
        decoded.pc          = fetch.pc;
        decoded.pcPlus4     = pcPlus4;
        decoded.instr       = fetch.instr;
        decoded.pcBranch    = jump ? jumpTarget : branchTarget;
        decoded.rd1         = rd1;
        decoded.rd2         = rd2;
        decoded.rs          = rs;
        decoded.rt          = rt;
        decoded.dest        = destIsRd ? rd : rt;
        decoded.imm         = imm;
        decoded.sa          = fetch.instr[10:6];
        decoded.aluControl  = aluControl;
        decoded.useImm      = useImm;
        decoded.regWrite    = regWrite;
        decoded.branch      = branch;
        decoded.jump        = jump;
        decoded.branchCond  = branchCond;
        decoded.predTake    = fetch.predTake;
        decoded.inDelaySlot = fetch.inDelaySlot;
    end

endmodule

`default_nettype wire

//--- logic/decodeExecuteReg.sv
`timescale 1ns/1ps
`default_nettype none

module decodeExecuteReg (
    input  logic                clk,
    input  logic                rstN,
    input  logic                stall,
    input  logic                flush,
    input  mipsPkg::decodePkt_t decoded,
    output mipsPkg::decodePkt_t held
);

    // flush wins over stall
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            held <= '0;
        end else if (flush) begin
            held <= '0;
        end else if (!stall) begin
            held <= decoded;
        end else begin
            held.valid <= 1'b0; // one-shot, held entry runs only once
        end
    end

endmodule

`default_nettype wire

//--- logic/executeStage.sv
`timescale 1ns/1ps
`default_nettype none

module executeStage (
    input  mipsPkg::decodePkt_t held,
    output mipsPkg::exResult_t  result,
    output mipsPkg::resolve_t   resolve,
    output mipsPkg::wbReq_t     wb
);

    mipsPkg::word_t srcA;
    mipsPkg::word_t srcB;
    mipsPkg::word_t aluOut;
    mipsPkg::word_t fallThrough;
    logic           condMet;
    logic           taken;
    logic           isControl;

    assign srcA = held.rd1;
    assign srcB = held.useImm ? held.imm : held.rd2;

    always_comb begin
        case (held.aluControl)
            mipsPkg::aluAdd: aluOut = srcA + srcB;
            mipsPkg::aluSub: aluOut = srcA - srcB;
            mipsPkg::aluAnd: aluOut = srcA & srcB;
            mipsPkg::aluOr:  aluOut = srcA | srcB;
            mipsPkg::aluXor: aluOut = srcA ^ srcB;
            mipsPkg::aluSlt: aluOut = {31'd0, $signed(srcA) < $signed(srcB)};
            mipsPkg::aluSll: aluOut = srcB << held.sa; // shifts act on rt
            mipsPkg::aluSrl: aluOut = srcB >> held.sa;
            mipsPkg::aluLui: aluOut = srcB;
            default:         aluOut = '0;
        endcase
    end

    // branch compare always uses the register operands
    always_comb begin
        case (held.branchCond)
            mipsPkg::brEq: condMet = (held.rd1 == held.rd2);
            mipsPkg::brNe: condMet = (held.rd1 != held.rd2);
            default:       condMet = 1'b0;
        endcase
    end

    assign isControl   = held.branch | held.jump;
    assign taken       = held.jump | (held.branch & condMet);
    assign fallThrough = held.pcPlus4 + 32'd4; // skip the delay slot

    always_comb begin
        resolve.valid      = held.valid & isControl;
        resolve.taken      = taken;
        resolve.mispredict = held.valid & isControl & (taken != held.predTake);
        resolve.target     = taken ? held.pcBranch : fallThrough;
    end

    always_comb begin
        wb.en   = held.valid & held.regWrite;
        wb.addr = held.dest;
        wb.data = aluOut;
    end

    always_comb begin
        result.valid    = held.valid;
        result.pc       = held.pc;
        result.dest     = held.dest;
        result.regWrite = held.regWrite;
        result.value    = aluOut;
    end

endmodule

`default_nettype wire

//--- logic/decodeExecuteUnit.sv
`timescale 1ns/1ps
`default_nettype none

module decodeExecuteUnit (
    input  logic               clk,
    input  logic               rstN,
    input  mipsPkg::fetchPkt_t fetch,
    input  logic               stall,
    input  logic               flush,
    output mipsPkg::exResult_t result,
    output mipsPkg::resolve_t  resolve
);

    mipsPkg::decodePkt_t decoded;
    mipsPkg::decodePkt_t held;
    mipsPkg::wbReq_t     wb;    // execute back into the register file

    decodeStage decodeStage_inst (
        .clk     (clk),
        .rstN    (rstN),
        .fetch   (fetch),
        .wb      (wb),
        .decoded (decoded)
    );

    decodeExecuteReg decodeExecuteReg_inst (
        .clk     (clk),
        .rstN    (rstN),
        .stall   (stall),
        .flush   (flush),
        .decoded (decoded),
        .held    (held)
    );

    executeStage executeStage_inst (
        .held    (held),
        .result  (result),
        .resolve (resolve),
        .wb      (wb)
    );

endmodule

`default_nettype wire

//--- verification/decodeExecuteUnitTb.sv
`timescale 1ns/1ps
`default_nettype none

module decodeExecuteUnitTb;

    typedef struct packed {
        logic [3:0]     group;
        mipsPkg::word_t instr;
        mipsPkg::word_t pc;
        logic           predTake;
        logic           stall;
        logic           flush;
        logic           expValid;   // a result is due one cycle later
    } row_t;

    localparam int waitLimit = 4;

    logic                clk;
    logic                rstN;
    logic                stall;
    logic                flush;
    mipsPkg::fetchPkt_t  fetch;
    mipsPkg::exResult_t  result;
    mipsPkg::resolve_t   resolve;

    row_t           rows[$];
    mipsPkg::word_t shadowRegs [32];
    mipsPkg::word_t nextPc;
    integer         seed;
    int             errors;
    int             checks;
    int             testsRun;
    int             testsBad;
    int             curGroup;
    int             groupErrStart;
    logic           timedOut;

    decodeExecuteUnit decodeExecuteUnit_inst (
        .clk     (clk),
        .rstN    (rstN),
        .fetch   (fetch),
        .stall   (stall),
        .flush   (flush),
        .result  (result),
        .resolve (resolve)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic mipsPkg::word_t rType(input logic [5:0] fn, input int rs, input int rt,
                                             input int rd, input int sa);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(sa), fn};
    endfunction

    function automatic mipsPkg::word_t iType(input logic [5:0] op, input int rs, input int rt,
                                             input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    function automatic mipsPkg::word_t jType(input logic [25:0] idx);
        return {mipsPkg::opJ, idx};
    endfunction

    function automatic logic [15:0] randHalf();
        mipsPkg::word_t r;
        r = $random(seed);
        return r[15:0];
    endfunction

    function automatic string groupName(input int g);
        case (g)
            1: return "reset state";
            2: return "alu operations";
            3: return "bypass";
            4: return "stall";
            5: return "flush";
            default: return "branch and jump";
        endcase
    endfunction

    task automatic addRow(input int grp, input mipsPkg::word_t instr, input int pt,
                          input int st, input int fl, input int ev);
        row_t r;
        r.group    = 4'(grp);
        r.instr    = instr;
        r.pc       = nextPc;
        r.predTake = (pt != 0);
        r.stall    = (st != 0);
        r.flush    = (fl != 0);
        r.expValid = (ev != 0);
        rows.push_back(r);
        if (st == 0) begin
            nextPc = nextPc + 32'd4;  // a stalled row is presented again
        end
    endtask

    task automatic buildTable();
        logic [15:0] h;
        logic [15:0] h2;
        nextPc = 32'h0040_0000;
        addRow(1, rType(mipsPkg::fnAddu, 7, 0, 3, 0), 0, 0, 0, 1);
        addRow(1, rType(mipsPkg::fnAddu, 31, 0, 4, 0), 0, 0, 0, 1);
        addRow(1, rType(mipsPkg::fnAddu, 0, 12, 5, 0), 0, 0, 0, 1);
        // random operands in r1 and r2
        h = randHalf();
        addRow(2, iType(mipsPkg::opLui, 0, 1, h), 0, 0, 0, 1);
        h = randHalf();
        addRow(2, iType(mipsPkg::opOri, 1, 1, h), 0, 0, 0, 1);
        h = randHalf();
        addRow(2, iType(mipsPkg::opLui, 0, 2, h), 0, 0, 0, 1);
        h = randHalf();
        addRow(2, iType(mipsPkg::opOri, 2, 2, h), 0, 0, 0, 1);
        addRow(2, iType(mipsPkg::opLui, 0, 14, 16'h8000), 0, 0, 0, 1); // negative for slt
        addRow(2, rType(mipsPkg::fnAddu, 1, 2, 3, 0), 0, 0, 0, 1);
        addRow(2, rType(mipsPkg::fnSubu, 1, 2, 4, 0), 0, 0, 0, 1);
        addRow(2, rType(mipsPkg::fnAnd, 1, 2, 5, 0), 0, 0, 0, 1);
        addRow(2, rType(mipsPkg::fnOr, 1, 2, 6, 0), 0, 0, 0, 1);
        addRow(2, rType(mipsPkg::fnXor, 1, 2, 7, 0), 0, 0, 0, 1);
        addRow(2, rType(mipsPkg::fnSlt, 1, 2, 8, 0), 0, 0, 0, 1);
        addRow(2, rType(mipsPkg::fnSlt, 2, 1, 9, 0), 0, 0, 0, 1);
        addRow(2, rType(mipsPkg::fnSlt, 14, 1, 15, 0), 0, 0, 0, 1);
        h = randHalf();
        addRow(2, rType(mipsPkg::fnSll, 0, 1, 10, int'(h[4:0])), 0, 0, 0, 1);
        h = randHalf();
        addRow(2, rType(mipsPkg::fnSrl, 0, 2, 11, int'(h[4:0])), 0, 0, 0, 1);
        h = randHalf();
        addRow(2, iType(mipsPkg::opAddiu, 1, 12, h), 0, 0, 0, 1);
        addRow(2, rType(mipsPkg::fnAddu, 1, 2, 0, 0), 0, 0, 0, 1);  // write to $0
        addRow(2, rType(mipsPkg::fnAddu, 0, 1, 13, 0), 0, 0, 0, 1);
        h = randHalf();
        addRow(3, iType(mipsPkg::opAddiu, 0, 16, h), 0, 0, 0, 1);
        addRow(3, rType(mipsPkg::fnAddu, 16, 16, 17, 0), 0, 0, 0, 1);
        addRow(3, rType(mipsPkg::fnSubu, 17, 1, 18, 0), 0, 0, 0, 1);
        addRow(3, rType(mipsPkg::fnXor, 18, 17, 19, 0), 0, 0, 0, 1);
        // addiu is not idempotent, a double write would show
        addRow(4, iType(mipsPkg::opAddiu, 20, 20, 16'd5), 0, 1, 0, 0);
        addRow(4, iType(mipsPkg::opAddiu, 20, 20, 16'd5), 0, 0, 0, 1);
        addRow(4, iType(mipsPkg::opAddiu, 20, 20, 16'd3), 0, 1, 0, 0);
        addRow(4, iType(mipsPkg::opAddiu, 20, 20, 16'd3), 0, 1, 0, 0);
        addRow(4, iType(mipsPkg::opAddiu, 20, 20, 16'd3), 0, 0, 0, 1);
        addRow(4, rType(mipsPkg::fnAddu, 20, 0, 21, 0), 0, 0, 0, 1);
        addRow(5, iType(mipsPkg::opAddiu, 0, 22, 16'h0077), 0, 0, 1, 0);
        addRow(5, rType(mipsPkg::fnAddu, 22, 0, 23, 0), 0, 0, 0, 1);
        addRow(5, iType(mipsPkg::opOri, 0, 24, 16'h0055), 0, 1, 1, 0);
        addRow(5, iType(mipsPkg::opOri, 0, 24, 16'h0055), 0, 0, 1, 0);
        addRow(5, rType(mipsPkg::fnAddu, 24, 0, 25, 0), 0, 0, 0, 1);
        addRow(6, iType(mipsPkg::opBeq, 1, 1, 16'h0010), 0, 0, 0, 1);
        addRow(6, iType(mipsPkg::opBeq, 1, 1, 16'hfff0), 1, 0, 0, 1);
        addRow(6, iType(mipsPkg::opBeq, 0, 0, 16'h0004), 0, 0, 0, 1);
        addRow(6, iType(mipsPkg::opBeq, 1, 2, 16'h0020), 1, 0, 0, 1);
        addRow(6, iType(mipsPkg::opBne, 1, 2, 16'h0008), 0, 0, 0, 1);
        addRow(6, iType(mipsPkg::opBne, 3, 3, 16'hfffc), 1, 0, 0, 1);
        h  = randHalf();
        h2 = randHalf();
        addRow(6, jType({h[9:0], h2}), 1, 0, 0, 1);
        h  = randHalf();
        h2 = randHalf();
        addRow(6, jType({h[9:0], h2}), 0, 0, 0, 1);
    endtask

    // shadow model of decode plus execute, updates the register copy
    task automatic predict(input row_t r, output mipsPkg::exResult_t er,
                           output mipsPkg::resolve_t rv);
        logic [5:0]        op;
        logic [5:0]        fn;
        mipsPkg::regAddr_t rs;
        mipsPkg::regAddr_t rt;
        mipsPkg::word_t    a;
        mipsPkg::word_t    b;
        mipsPkg::word_t    se;
        mipsPkg::word_t    pc4;
        op  = r.instr[31:26];
        fn  = r.instr[5:0];
        rs  = r.instr[25:21];
        rt  = r.instr[20:16];
        a   = shadowRegs[rs];
        b   = shadowRegs[rt];
        se  = {{16{r.instr[15]}}, r.instr[15:0]};
        pc4 = r.pc + 32'd4;
        er = '0;
        rv = '0;
        er.valid = 1'b1;
        er.pc    = r.pc;
        er.dest  = rt;
        case (op)
            mipsPkg::opSpecial: begin
                er.dest     = r.instr[15:11];
                er.regWrite = 1'b1;
                case (fn)
                    mipsPkg::fnAddu: er.value = a + b;
                    mipsPkg::fnSubu: er.value = a - b;
                    mipsPkg::fnAnd:  er.value = a & b;
                    mipsPkg::fnOr:   er.value = a | b;
                    mipsPkg::fnXor:  er.value = a ^ b;
                    mipsPkg::fnSlt:  er.value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    mipsPkg::fnSll:  er.value = b << r.instr[10:6];
                    mipsPkg::fnSrl:  er.value = b >> r.instr[10:6];
                    default:         er.regWrite = 1'b0;
                endcase
            end
            mipsPkg::opAddiu: begin
                er.regWrite = 1'b1;
                er.value    = a + se;
            end
            mipsPkg::opOri: begin
                er.regWrite = 1'b1;
                er.value    = a | {16'h0000, r.instr[15:0]};
            end
            mipsPkg::opLui: begin
                er.regWrite = 1'b1;
                er.value    = {r.instr[15:0], 16'h0000};
            end
            mipsPkg::opBeq, mipsPkg::opBne: begin
                rv.valid  = 1'b1;
                rv.taken  = (op == mipsPkg::opBeq) ? (a == b) : (a != b);
                rv.target = rv.taken ? pc4 + {se[29:0], 2'b00} : r.pc + 32'd8;
            end
            mipsPkg::opJ: begin
                rv.valid  = 1'b1;
                rv.taken  = 1'b1;
                rv.target = {pc4[31:28], r.instr[25:0], 2'b00};
            end
            default: ;
        endcase
        rv.mispredict = rv.valid && (rv.taken != r.predTake);
        if (er.regWrite && er.dest != '0) begin
            shadowRegs[er.dest] = er.value;
        end
    endtask

    task automatic flagMismatch(input string sig, input mipsPkg::word_t got,
                                input mipsPkg::word_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("ERR t=%0t %s got %h expected %h", $time, sig, got, want);
        end
    endtask

    task automatic checkResult(input mipsPkg::exResult_t got, input mipsPkg::exResult_t want);
        flagMismatch("result.valid", 32'(got.valid), 32'(want.valid));
        if (want.valid) begin
            flagMismatch("result.pc", got.pc, want.pc);
            flagMismatch("result.regWrite", 32'(got.regWrite), 32'(want.regWrite));
            if (want.regWrite) begin
                flagMismatch("result.dest", 32'(got.dest), 32'(want.dest));
                flagMismatch("result.value", got.value, want.value);
            end
        end
    endtask

    task automatic checkResolve(input mipsPkg::resolve_t got, input mipsPkg::resolve_t want);
        flagMismatch("resolve.valid", 32'(got.valid), 32'(want.valid));
        if (want.valid) begin
            flagMismatch("resolve.taken", 32'(got.taken), 32'(want.taken));
            flagMismatch("resolve.mispredict", 32'(got.mispredict), 32'(want.mispredict));
            flagMismatch("resolve.target", got.target, want.target);
        end
    endtask

    // called on a falling edge, returns on the falling edge where the row was checked
    task automatic applyRow(input int idx);
        row_t               r;
        mipsPkg::exResult_t expRes;
        mipsPkg::resolve_t  expRsv;
        int                 cycles;
        logic               seen;
        r = rows[idx];
        fetch.valid       = 1'b1;
        fetch.pc          = r.pc;
        fetch.instr       = r.instr;
        fetch.predTake    = r.predTake;
        fetch.inDelaySlot = 1'b0;
        stall             = r.stall;
        flush             = r.flush;
        @(posedge clk);
        expRes = '0;
        expRsv = '0;
        if (r.expValid) begin
            predict(r, expRes, expRsv);
        end
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < waitLimit) begin
            @(negedge clk);
            cycles++;
            seen = !r.expValid || result.valid;
            fetch.valid = 1'b0;  // idle until the next row
            stall       = 1'b0;
            flush       = 1'b0;
        end
        if (!seen) begin
            $display("timeout: row %0d gave no result within %0d cycles", idx, waitLimit);
            errors++;
            timedOut = 1'b1;
        end else begin
            if (cycles != 1) begin
                $display("row %0d: result came %0d cycles after acceptance, not 1", idx, cycles);
                errors++;
            end
            checkResult(result, expRes);
            checkResolve(resolve, expRsv);
        end
    endtask

    task automatic closeGroup();
        testsRun++;
        if (errors == groupErrStart) begin
            $display("test %0d %s: ok", curGroup, groupName(curGroup));
        end else begin
            testsBad++;
            $display("test %0d %s: %0d errors", curGroup, groupName(curGroup),
                     errors - groupErrStart);
        end
    endtask

    initial begin
        seed     = 32'h56a2;
        rstN     = 1'b0;
        stall    = 1'b0;
        flush    = 1'b0;
        fetch    = '0;
        errors   = 0;
        checks   = 0;
        testsRun = 0;
        testsBad = 0;
        timedOut = 1'b0;
        for (int i = 0; i < 32; i++) begin
            shadowRegs[i] = '0;
        end
        buildTable();
        curGroup      = 1;
        groupErrStart = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        checkResult(result, '0);
        checkResolve(resolve, '0);
        rstN = 1'b1;
        for (int i = 0; i < rows.size(); i++) begin
            if (int'(rows[i].group) != curGroup) begin
                closeGroup();
                curGroup      = int'(rows[i].group);
                groupErrStart = errors;
            end
            applyRow(i);
            if (timedOut) begin
                break;
            end
        end
        closeGroup();
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 testsRun, testsBad, checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- decodeExecuteUnit.f
logic/mipsPkg.sv
logic/decodeStage.sv
logic/decodeExecuteReg.sv
logic/executeStage.sv
logic/decodeExecuteUnit.sv
verification/decodeExecuteUnitTb.sv

//--- Makefile
# Verilator build and run for the decode/execute slice

VERILATOR ?= verilator
TOP       ?= decodeExecuteUnitTb
FILELIST  ?= decodeExecuteUnit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
FAIL_MSG  ?= Test failed

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(SIM_BIN) > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation FAILED, see $(LOG)"; exit 1; fi
	@echo "simulation passed"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
